//--- files.f
vid_pkg.sv
vid_timing.sv
vid_tile_layer.sv
vid_vdp_plane.sv
vid_colmix.sv
vid_top.sv
tb_vid_top.sv

//--- run_sim.sh
#!/bin/bash
# build and run the video testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_vid_top -f files.f -o sim_vid \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_vid > sim.log 2>&1

grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

//--- tb_vid_top.sv
// testbench for vid_top: clock, reset, lfsr, ram/register mirror, reference model, compare, timeout
`timescale 1ns/1ps

module tb_vid_top;
    import vid_pkg::*;

    localparam int FRAME_CEN = H_TOTAL * V_TOTAL;   // 448 pxl_cen per frame
    localparam int FRAME_CLK = 2 * FRAME_CEN;       // pxl_cen every second clock
    localparam int TIMEOUT   = 8 * FRAME_CLK + 832;  // eight checked frames plus the write phase

    logic clk = 1'b0;
    logic reset, pxl_cen, gray_n, tile_valid, tile_ready, vdp_we;
    mix_mode_e mix_mode;
    logic [TILE_AW-1:0] tile_addr;
    logic [CPU_DW-1:0] tile_din, vdp_din;
    logic [VDP_AW-1:0] vdp_addr;
    logic HS, VS, LHBL, LVBL, LHBL_dly, LVBL_dly;
    logic [VID_CW-1:0] red, green, blue;

    // mirror of the dut memories and registers
    int map_m [MAP_DEPTH];
    int pat_m [PAT_DEPTH];
    int pal_m [PAL_DEPTH];
    int stg_m [NUM_REGS];
    int act_m [NUM_REGS];

    logic [15:0] lfsr = 16'd94;
    logic check_en = 1'b0;
    int cycles = 0, frames_seen = 0, pix_checked = 0;

    vid_top u_dut (.*);

    always #50 clk = !clk;  // 100 ns period

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r = {r[14:0], fb};
        end
        return r;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("ERR %s exp 0x%0h got 0x%0h", name, exp, got);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // expected colour at raster position h,v from the mirror contents
    function automatic logic [23:0] expect_rgb(input int h, input int v,
                                               input mix_mode_e m, input logic g_n);
        int code, row, idx, p, r5, g6, b5, tr, tg, tb, vr, vg, vb, r, g, b, gr;
        logic opq, hit;
        code = map_m[(v / TILE_SIZE) * MAP_COLS + h / TILE_SIZE];
        row  = pat_m[code * TILE_SIZE + v % TILE_SIZE];
        idx  = (row >> ((TILE_SIZE - 1 - h % TILE_SIZE) * 4)) & 15;  // leftmost in top nibble
        p    = pal_m[idx];
        r5 = (p >> 11) & 31;
        g6 = (p >> 5) & 63;
        b5 = p & 31;
        tr = (r5 * 2 + r5 / 16) * 4 + r5 / 8;  // 5 -> 6 -> 8, top bits repeated
        tg = g6 * 4 + g6 / 16;
        tb = (b5 * 2 + b5 / 16) * 4 + b5 / 8;
        opq = idx != 0;
        hit = (act_m[REG_BACK_B] & 1) != 0
           && h >= (act_m[REG_RECT_X] >> 8) && h <= (act_m[REG_RECT_X] & 255)
           && v >= (act_m[REG_RECT_Y] >> 8) && v <= (act_m[REG_RECT_Y] & 255);
        vr = hit ? act_m[REG_RECT_RG] >> 8  : act_m[REG_BACK_RG] >> 8;
        vg = hit ? act_m[REG_RECT_RG] & 255 : act_m[REG_BACK_RG] & 255;
        vb = hit ? act_m[REG_RECT_B] >> 8   : act_m[REG_BACK_B] >> 8;
        r = vr;  // default vdp
        g = vg;
        b = vb;
        if ((m == MIX_TILE_OVER && opq) || (m == MIX_VDP_OVER && !hit && opq)
                || (m == MIX_TILE_ONLY && opq)) begin
            r = tr;
            g = tg;
            b = tb;
        end else if (m == MIX_TILE_ONLY) begin
            r = 0;  // nothing behind the tiles
            g = 0;
            b = 0;
        end
        if (!g_n) begin
            gr = (r + 2 * g + b) / 4;
            r = gr;
            g = gr;
            b = gr;
        end
        return {r[7:0], g[7:0], b[7:0]};
    endfunction

    // write through the handshake, held until accepted
    task automatic tile_write(input int addr, input int data);
        logic acc;
        @(posedge clk);
        tile_valid <= 1'b1;
        tile_addr  <= addr[7:0];
        tile_din   <= data[15:0];
        acc = 1'b0;
        while (!acc) begin
            @(negedge clk);
            acc = tile_ready;  // stable until the edge
            @(posedge clk);
        end
        tile_valid <= 1'b0;
        if (addr < 'h40) map_m[addr] = data & 15;
        else if (addr < 'h80) pat_m[addr - 'h40] = data;
        else pal_m[addr - 'h80] = data;
    endtask

    // vdp writes only inside the visible frame, never on the wrap
    task automatic vdp_write(input int idx, input int data);
        do @(negedge clk); while (!LVBL);
        @(posedge clk);
        vdp_we   <= 1'b1;
        vdp_addr <= idx[2:0];
        vdp_din  <= data[15:0];
        @(posedge clk);
        vdp_we <= 1'b0;
        stg_m[idx] = data;
    endtask

    // mode changes land while both raw and delayed frames are blank
    task automatic set_mode(input mix_mode_e m, input logic g_n);
        do @(negedge clk); while (LVBL || LVBL_dly);
        @(posedge clk);
        mix_mode <= m;
        gray_n   <= g_n;
    endtask

    task automatic wait_frame();
        do @(negedge clk); while (!LVBL_dly);
        do @(negedge clk); while (LVBL_dly);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT)
            fail_run("timeout: test did not finish within the cycle limit");
    end

    // pxl_cen registered every second clock
    always @(posedge clk) pxl_cen <= !pxl_cen;

    // compare process, sampled on the falling edge after each pxl_cen
    int h_pos = 0, v_pos = 0, cen_cnt = 0, hs_cnt = 0;
    logic prev_hb = 1'b0, prev_vb = 1'b0, prev_vs = 1'b0, prev_lv = 1'b0, vs_seen = 1'b0;
    logic prev_hs = 1'b0, prev_lh = 1'b0;
    logic [23:0] exp_rgb;

    always @(negedge clk) begin
        if (!reset) begin
            if (tile_ready && LHBL && LVBL)
                fail_run("tile_ready high during active display");
        end
        if (!reset && !pxl_cen) begin
            cen_cnt++;
            hs_cnt++;
            if (!LHBL && prev_lh)
                hs_cnt = 0;  // line blanking starts at h = H_ACTIVE
            if (HS && !prev_hs)
                check("hs_start", H_SYNC_START - H_ACTIVE, hs_cnt);
            if (!HS && prev_hs)
                check("hs_end", H_SYNC_START + H_SYNC_LEN - H_ACTIVE, hs_cnt);
            if (!LHBL_dly && prev_hb)
                check("lhbl_dly", MIX_DLY, hs_cnt);  // delayed flag trails LHBL
            if (VS && !prev_vs) begin
                if (vs_seen) check("vs_period", FRAME_CEN, cen_cnt);
                vs_seen = 1'b1;
                cen_cnt = 0;
            end
            if (LVBL && !prev_lv) begin
                for (int i = 0; i < NUM_REGS; i++) act_m[i] = stg_m[i];  // frame wrap copy
            end
            if (LVBL_dly && !prev_vb) begin
                h_pos = 0;
                v_pos = 0;
                frames_seen++;
            end
            if (!(LHBL_dly && LVBL_dly)) begin
                check("red_blank", 0, red);
                check("green_blank", 0, green);
                check("blue_blank", 0, blue);
                if (prev_hb && prev_vb && !LHBL_dly) begin
                    check("line_pixels", H_ACTIVE, h_pos);
                    h_pos = 0;
                    v_pos++;
                end
            end else begin
                if (check_en) begin
                    exp_rgb = expect_rgb(h_pos, v_pos, mix_mode, gray_n);
                    check("red", exp_rgb[23:16], red);
                    check("green", exp_rgb[15:8], green);
                    check("blue", exp_rgb[7:0], blue);
                    pix_checked++;
                end
                h_pos++;
            end
            prev_hb = LHBL_dly;
            prev_vb = LVBL_dly;
            prev_vs = VS;
            prev_lv = LVBL;
            prev_hs = HS;
            prev_lh = LHBL;
        end
    end

    initial begin
        reset = 1'b1;
        pxl_cen = 1'b0;
        mix_mode = MIX_TILE_ONLY;
        gray_n = 1'b1;
        tile_valid = 1'b0;
        tile_addr = '0;
        tile_din = '0;
        vdp_we = 1'b0;
        vdp_addr = '0;
        vdp_din = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            stg_m[i] = 0;
            act_m[i] = 0;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // fill every tile ram word, random gaps between requests
        for (int a = 0; a < MAP_DEPTH + PAT_DEPTH + PAL_DEPTH; a++) begin
            repeat (rand_bits(3)) @(posedge clk);
            if (a < MAP_DEPTH) tile_write('h00 + a, rand_bits(4));
            else if (a < MAP_DEPTH + PAT_DEPTH) tile_write('h40 + a - MAP_DEPTH, rand_bits(16));
            else tile_write('h80 + a - MAP_DEPTH - PAT_DEPTH, rand_bits(16));
        end

        set_mode(MIX_TILE_ONLY, 1'b1);
        check_en = 1'b1;  // rams settled from here on
        wait_frame();

        // backdrop and rectangle, then a mid-frame move
        set_mode(MIX_VDP_ONLY, 1'b1);
        vdp_write(REG_BACK_RG, rand_bits(16));
        vdp_write(REG_BACK_B, {rand_bits(8), 8'h01});
        vdp_write(REG_RECT_X, 16'h040b);
        vdp_write(REG_RECT_Y, 16'h0205);
        vdp_write(REG_RECT_RG, rand_bits(16));
        vdp_write(REG_RECT_B, {rand_bits(8), 8'h00});
        wait_frame();
        wait_frame();
        do @(negedge clk); while (!LVBL);
        repeat (200) @(posedge clk);  // about line 3 of the visible frame
        vdp_write(REG_RECT_X, 16'h0007);
        vdp_write(REG_RECT_Y, 16'h0307);
        wait_frame();
        wait_frame();

        set_mode(MIX_TILE_OVER, 1'b1);
        wait_frame();
        set_mode(MIX_VDP_OVER, 1'b1);
        wait_frame();
        set_mode(MIX_VDP_OVER, 1'b0);  // gray
        wait_frame();

        if (pix_checked < 6 * H_ACTIVE * V_ACTIVE || frames_seen < 6) begin
            $display("too few frames or pixels reached the checks");
            $display("sim failed");
            $fatal(1);
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

//--- vid_top.sv
// video subsystem top: timing, tile plane, vdp plane and colour mixer
`timescale 1ns/1ps

module vid_top import vid_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               pxl_cen,
    input  mix_mode_e          mix_mode,
    input  logic               gray_n,
    // tile plane cpu port
    input  logic               tile_valid,
    input  logic [TILE_AW-1:0] tile_addr,
    input  logic [CPU_DW-1:0]  tile_din,
    output logic               tile_ready,
    // vdp cpu port
    input  logic               vdp_we,
    input  logic [VDP_AW-1:0]  vdp_addr,
    input  logic [CPU_DW-1:0]  vdp_din,
    // video
    output logic               HS,
    output logic               VS,
    output logic               LHBL,
    output logic               LVBL,
    output logic               LHBL_dly,
    output logic               LVBL_dly,
    output logic [VID_CW-1:0]  red,
    output logic [VID_CW-1:0]  green,
    output logic [VID_CW-1:0]  blue
);

    logic [HW-1:0]      hdump;
    logic [VW-1:0]      vdump;
    logic [TILE_CW-1:0] tile_r, tile_g, tile_b;
    logic               tile_opaque;
    logic [VID_CW-1:0]  vdp_r, vdp_g, vdp_b;
    logic               rect_hit;

    vid_timing u_timing (
        .clk(clk), .reset(reset), .pxl_cen(pxl_cen),
        .hdump(hdump), .vdump(vdump),
        .HS(HS), .VS(VS), .LHBL(LHBL), .LVBL(LVBL)
    );

    vid_tile_layer u_tile (
        .clk(clk), .reset(reset), .pxl_cen(pxl_cen),
        .hdump(hdump), .vdump(vdump), .LHBL(LHBL), .LVBL(LVBL),
        .tile_valid(tile_valid), .tile_addr(tile_addr), .tile_din(tile_din),
        .tile_ready(tile_ready),
        .tile_r(tile_r), .tile_g(tile_g), .tile_b(tile_b), .tile_opaque(tile_opaque)
    );

    vid_vdp_plane u_vdp (
        .clk(clk), .reset(reset), .pxl_cen(pxl_cen),
        .hdump(hdump), .vdump(vdump),
        .vdp_we(vdp_we), .vdp_addr(vdp_addr), .vdp_din(vdp_din),
        .vdp_r(vdp_r), .vdp_g(vdp_g), .vdp_b(vdp_b), .rect_hit(rect_hit)
    );

    vid_colmix u_colmix (
        .clk(clk), .reset(reset), .pxl_cen(pxl_cen),
        .LHBL(LHBL), .LVBL(LVBL), .mix_mode(mix_mode), .gray_n(gray_n),
        .tile_r(tile_r), .tile_g(tile_g), .tile_b(tile_b), .tile_opaque(tile_opaque),
        .vdp_r(vdp_r), .vdp_g(vdp_g), .vdp_b(vdp_b), .rect_hit(rect_hit),
        .red(red), .green(green), .blue(blue),
        .LHBL_dly(LHBL_dly), .LVBL_dly(LVBL_dly)
    );

endmodule

//--- vid_colmix.sv
// colour mixer: plane priority, 6 to 8 bit expansion, gray conversion, blanking delay
`timescale 1ns/1ps

module vid_colmix import vid_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               pxl_cen,
    input  logic               LHBL,
    input  logic               LVBL,
    input  mix_mode_e          mix_mode,
    input  logic               gray_n,
    input  logic [TILE_CW-1:0] tile_r,
    input  logic [TILE_CW-1:0] tile_g,
    input  logic [TILE_CW-1:0] tile_b,
    input  logic               tile_opaque,
    input  logic [VID_CW-1:0]  vdp_r,
    input  logic [VID_CW-1:0]  vdp_g,
    input  logic [VID_CW-1:0]  vdp_b,
    input  logic               rect_hit,
    output logic [VID_CW-1:0]  red,
    output logic [VID_CW-1:0]  green,
    output logic [VID_CW-1:0]  blue,
    output logic               LHBL_dly,
    output logic               LVBL_dly
);

    logic [MIX_DLY-1:0] hb_sr, vb_sr;  // blanking delay lines
    logic [VID_CW-1:0]  tr8, tg8, tb8;
    logic               use_tile, use_vdp;
    logic [VID_CW-1:0]  mr, mg, mb;
    logic [VID_CW+1:0]  gsum;          // r + 2g + b, 10 bits
    logic [VID_CW-1:0]  gray;
    logic               vis_nxt;

    assign tr8 = {tile_r, tile_r[TILE_CW-1 -: 2]};  // top bits repeated
    assign tg8 = {tile_g, tile_g[TILE_CW-1 -: 2]};
    assign tb8 = {tile_b, tile_b[TILE_CW-1 -: 2]};

    always_comb begin
        use_tile = 1'b0;
        use_vdp  = 1'b0;
        case (mix_mode)
            MIX_TILE_OVER: begin
                use_tile = tile_opaque;
                use_vdp  = !tile_opaque;
            end
            MIX_VDP_OVER: begin
                use_tile = !rect_hit && tile_opaque;  // rectangle wins
                use_vdp  = rect_hit || !tile_opaque;
            end
            MIX_TILE_ONLY: use_tile = tile_opaque;    // black behind
            MIX_VDP_ONLY:  use_vdp  = 1'b1;
            default: ;
        endcase
    end

    assign mr = use_tile ? tr8 : use_vdp ? vdp_r : '0;
    assign mg = use_tile ? tg8 : use_vdp ? vdp_g : '0;
    assign mb = use_tile ? tb8 : use_vdp ? vdp_b : '0;

    assign gsum = {2'b0, mr} + {1'b0, mg, 1'b0} + {2'b0, mb};
    assign gray = gsum[VID_CW+1:2];  // /4, truncated

    // flags that will be LHBL_dly/LVBL_dly after this pxl_cen
    assign vis_nxt = hb_sr[MIX_DLY-2] && vb_sr[MIX_DLY-2];

    always_ff @(posedge clk) begin
        if (reset) begin
            hb_sr <= '0;
            vb_sr <= '0;
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (pxl_cen) begin
            hb_sr <= {hb_sr[MIX_DLY-2:0], LHBL};
            vb_sr <= {vb_sr[MIX_DLY-2:0], LVBL};
            red   <= !vis_nxt ? '0 : gray_n ? mr : gray;
            green <= !vis_nxt ? '0 : gray_n ? mg : gray;
            blue  <= !vis_nxt ? '0 : gray_n ? mb : gray;
        end
    end

    assign LHBL_dly = hb_sr[MIX_DLY-1];
    assign LVBL_dly = vb_sr[MIX_DLY-1];

    // delayed flags and colour stay aligned through the whole pipe
    a_blank_black: assert property (@(posedge clk) disable iff (reset)
        !(LHBL_dly && LVBL_dly) |-> (red == '0 && green == '0 && blue == '0))
        else $error("colmix: colour out during blanking");

endmodule

//--- vid_vdp_plane.sv
// second plane: staged cpu registers, frame-start copy, backdrop and rectangle pixel pipeline
`timescale 1ns/1ps

module vid_vdp_plane import vid_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              pxl_cen,
    input  logic [HW-1:0]     hdump,
    input  logic [VW-1:0]     vdump,
    // cpu write port, no back-pressure
    input  logic              vdp_we,
    input  logic [VDP_AW-1:0] vdp_addr,
    input  logic [CPU_DW-1:0] vdp_din,
    // pixel out, matches tile plane latency
    output logic [VID_CW-1:0] vdp_r,
    output logic [VID_CW-1:0] vdp_g,
    output logic [VID_CW-1:0] vdp_b,
    output logic              rect_hit
);

    logic [CPU_DW-1:0] stg [NUM_REGS];  // cpu side
    logic [CPU_DW-1:0] act [NUM_REGS];  // what the beam sees
    logic              frame_wrap;
    logic [7:0]        h8, v8;
    logic              in_rect;
    logic              s1_hit;
    logic [VID_CW-1:0] s1_r, s1_g, s1_b;

    // last position of the frame, counters go to 0,0 on this pxl_cen
    assign frame_wrap = pxl_cen && hdump == HW'(H_TOTAL - 1) && vdump == VW'(V_TOTAL - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                stg[i] <= '0;
                act[i] <= '0;  // rectangle off, black backdrop
            end
        end else begin
            if (vdp_we && int'(vdp_addr) < NUM_REGS)
                stg[vdp_addr] <= vdp_din;
            if (frame_wrap)
                act <= stg;  // new values only from the next frame
        end
    end

    assign h8 = 8'(hdump);
    assign v8 = 8'(vdump);

    // bounds inclusive on both sides
    assign in_rect = act[REG_BACK_B][RECT_EN_BIT]
                  && h8 >= act[REG_RECT_X][15:8] && h8 <= act[REG_RECT_X][7:0]
                  && v8 >= act[REG_RECT_Y][15:8] && v8 <= act[REG_RECT_Y][7:0];

    // stage 1, colour select
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            s1_r <= in_rect ? act[REG_RECT_RG][15:8] : act[REG_BACK_RG][15:8];
            s1_g <= in_rect ? act[REG_RECT_RG][7:0]  : act[REG_BACK_RG][7:0];
            s1_b <= in_rect ? act[REG_RECT_B][15:8]  : act[REG_BACK_B][15:8];
        end
    end

    // stage 2, plain delay
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            vdp_r <= s1_r;
            vdp_g <= s1_g;
            vdp_b <= s1_b;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_hit   <= 1'b0;
            rect_hit <= 1'b0;
        end else if (pxl_cen) begin
            s1_hit   <= in_rect;
            rect_hit <= s1_hit;
        end
    end

endmodule

//--- vid_tile_layer.sv
// tile plane: cpu write port with handshake, map/pattern/palette rams, two-stage pixel pipeline
`timescale 1ns/1ps

module vid_tile_layer import vid_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               pxl_cen,
    input  logic [HW-1:0]      hdump,
    input  logic [VW-1:0]      vdump,
    input  logic               LHBL,
    input  logic               LVBL,
    // cpu write port
    input  logic               tile_valid,
    input  logic [TILE_AW-1:0] tile_addr,
    input  logic [CPU_DW-1:0]  tile_din,
    output logic               tile_ready,
    // pixel out, two pxl_cen behind hdump/vdump
    output logic [TILE_CW-1:0] tile_r,
    output logic [TILE_CW-1:0] tile_g,
    output logic [TILE_CW-1:0] tile_b,
    output logic               tile_opaque
);

    logic [CODE_W-1:0]  map_ram [MAP_DEPTH];
    logic [PAT_W-1:0]   pat_ram [PAT_DEPTH];
    logic [PAL_W-1:0]   pal_ram [PAL_DEPTH];

    logic [TILE_AW-1:0] map_off, pat_off, pal_off;
    logic               wr_en;
    logic               map_we, pat_we, pal_we;

    tile_stage_e        st;
    logic [MAP_AW-1:0]  map_idx;
    logic [CODE_W-1:0]  s1_code;   // stage 1 payload
    logic [TW-1:0]      s1_col;
    logic [TW-1:0]      s1_row;
    logic [PAT_W-1:0]   pat_row;
    logic [PIX_W-1:0]   pix_idx;
    logic [PAL_W-1:0]   pal_word;

    // rams are free in blanking once the last active pixel has left stage 1
    assign tile_ready = !(LHBL && LVBL) && st != ST_PIXEL;
    assign wr_en      = tile_valid && tile_ready;

    // region decode, offsets wrap below each base
    assign map_off = tile_addr - MAP_BASE;
    assign pat_off = tile_addr - PAT_BASE;
    assign pal_off = tile_addr - PAL_BASE;
    assign map_we  = wr_en && map_off < TILE_AW'(MAP_DEPTH);
    assign pat_we  = wr_en && pat_off < TILE_AW'(PAT_DEPTH);
    assign pal_we  = wr_en && pal_off < TILE_AW'(PAL_DEPTH);

    always_ff @(posedge clk) begin
        if (map_we) map_ram[map_off[MAP_AW-1:0]] <= tile_din[CODE_W-1:0];
        if (pat_we) pat_ram[pat_off[PAT_AW-1:0]] <= tile_din;
        if (pal_we) pal_ram[pal_off[PIX_W-1:0]]  <= tile_din;
    end

    // stage 1, map lookup for the tile under the beam
    assign map_idx = {vdump[TW +: ROW_AW], hdump[TW +: COL_AW]};

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            s1_code <= map_ram[map_idx];
            s1_col  <= hdump[TW-1:0];  // pixel inside tile
            s1_row  <= vdump[TW-1:0];  // line inside tile
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            st <= ST_IDLE;
        else if (pxl_cen)
            st <= (LHBL && LVBL) ? ST_PIXEL : ST_MAP;
    end

    // stage 2, pattern row -> colour index -> palette
    assign pat_row  = pat_ram[{s1_code, s1_row}];
    assign pix_idx  = pat_row[(TILE_SIZE - 1 - int'(s1_col)) * PIX_W +: PIX_W];
    assign pal_word = pal_ram[pix_idx];

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            tile_r <= {pal_word[15:11], pal_word[15]};  // 5 -> 6 bits
            tile_g <=  pal_word[10:5];
            tile_b <= {pal_word[4:0],   pal_word[4]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            tile_opaque <= 1'b0;
        else if (pxl_cen)
            tile_opaque <= st != ST_IDLE && pix_idx != '0;  // index 0 is see-through
    end

    // cpu writes never land while the beam is on a visible position
    a_no_active_wr: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> !(int'(hdump) < H_ACTIVE && int'(vdump) < V_ACTIVE))
        else $error("tile: write accepted in active display");

endmodule

//--- vid_timing.sv
// raster timing: pixel and line counters, registered sync and blanking flags
`timescale 1ns/1ps

module vid_timing import vid_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          pxl_cen,
    output logic [HW-1:0] hdump,
    output logic [VW-1:0] vdump,
    output logic          HS,
    output logic          VS,
    output logic          LHBL,
    output logic          LVBL
);

    logic [HW-1:0] h_nxt;
    logic [VW-1:0] v_nxt;
    logic          h_wrap;
    logic          v_wrap;

    assign h_wrap = hdump == HW'(H_TOTAL - 1);
    assign v_wrap = vdump == VW'(V_TOTAL - 1);

    assign h_nxt = h_wrap ? '0 : hdump + 1'd1;
    // line counter only moves at end of line
    assign v_nxt = !h_wrap ? vdump :
                   v_wrap  ? '0    : vdump + 1'd1;

    // flags decoded from the next count, so they line up with hdump/vdump
    always_ff @(posedge clk) begin
        if (reset) begin
            hdump <= '0;
            vdump <= '0;
            HS    <= 1'b0;
            VS    <= 1'b0;
            LHBL  <= 1'b1;  // 0,0 is visible
            LVBL  <= 1'b1;
        end else if (pxl_cen) begin
            hdump <= h_nxt;
            vdump <= v_nxt;
            LHBL  <= h_nxt < HW'(H_ACTIVE);
            LVBL  <= v_nxt < VW'(V_ACTIVE);
            HS    <= h_nxt >= HW'(H_SYNC_START) &&
                     h_nxt <  HW'(H_SYNC_START + H_SYNC_LEN);
            VS    <= v_nxt >= VW'(V_SYNC_START) &&
                     v_nxt <  VW'(V_SYNC_START + V_SYNC_LEN);
        end
    end

    // counters stay inside the raster
    a_cnt_range: assert property (@(posedge clk) disable iff (reset)
        int'(hdump) < H_TOTAL && int'(vdump) < V_TOTAL)
        else $error("timing: counter out of range h=%0d v=%0d", hdump, vdump);

endmodule

//--- vid_pkg.sv
// raster, tile and colour constants, cpu address map, vdp register indices, mixer and tile enums
package vid_pkg;

    // raster, kept tiny for short simulations
    localparam int H_TOTAL      = 32;  // pixels per line
    localparam int H_ACTIVE     = 16;
    localparam int V_TOTAL      = 14;  // lines per frame
    localparam int V_ACTIVE     = 8;
    localparam int H_SYNC_START = 20;
    localparam int H_SYNC_LEN   = 4;
    localparam int V_SYNC_START = 10;
    localparam int V_SYNC_LEN   = 2;
    localparam int HW           = 5;   // hdump width
    localparam int VW           = 4;   // vdump width

    // tile geometry
    localparam int TILE_SIZE = 4;  // square, in pixels
    localparam int MAP_COLS  = 4;
    localparam int MAP_ROWS  = 2;
    localparam int NUM_TILES = 16;
    localparam int TW        = $clog2(TILE_SIZE);  // pixel position inside a tile
    localparam int COL_AW    = $clog2(MAP_COLS);
    localparam int ROW_AW    = $clog2(MAP_ROWS);
    localparam int CODE_W    = $clog2(NUM_TILES);  // map entry = tile code
    localparam int PIX_W     = 4;                  // colour index per pixel

    // tile memory sizes
    localparam int MAP_AW    = ROW_AW + COL_AW;
    localparam int MAP_DEPTH = MAP_COLS * MAP_ROWS;   // 8 entries
    localparam int PAT_AW    = CODE_W + TW;
    localparam int PAT_DEPTH = NUM_TILES * TILE_SIZE; // one row per tile line
    localparam int PAT_W     = PIX_W * TILE_SIZE;     // 16, leftmost pixel in top nibble
    localparam int PAL_DEPTH = 1 << PIX_W;

    // colour widths
    localparam int PAL_W   = 16;  // 5:6:5 rgb
    localparam int TILE_CW = 6;   // tile plane output per channel
    localparam int VID_CW  = 8;   // vdp plane and final output

    // cpu side
    localparam int CPU_DW  = 16;
    localparam int TILE_AW = 8;
    localparam int VDP_AW  = 3;

    // tile plane address map
    localparam logic [TILE_AW-1:0] MAP_BASE = 8'h00;
    localparam logic [TILE_AW-1:0] PAT_BASE = 8'h40;
    localparam logic [TILE_AW-1:0] PAL_BASE = 8'h80;

    // vdp registers, rg words hold red high and green low, b words hold blue high
    localparam logic [VDP_AW-1:0] REG_BACK_RG = 3'd0;
    localparam logic [VDP_AW-1:0] REG_BACK_B  = 3'd1;  // bit 0 = rectangle enable
    localparam logic [VDP_AW-1:0] REG_RECT_X  = 3'd2;  // x0 high byte, x1 low byte
    localparam logic [VDP_AW-1:0] REG_RECT_Y  = 3'd3;  // y0 high byte, y1 low byte
    localparam logic [VDP_AW-1:0] REG_RECT_RG = 3'd4;
    localparam logic [VDP_AW-1:0] REG_RECT_B  = 3'd5;
    localparam int NUM_REGS    = 6;
    localparam int RECT_EN_BIT = 0;

    localparam int MIX_DLY = 3;  // pxl_cen from position to rgb

    typedef enum logic [1:0] {
        MIX_TILE_OVER,
        MIX_VDP_OVER,
        MIX_TILE_ONLY,
        MIX_VDP_ONLY
    } mix_mode_e;

    typedef enum logic [1:0] {
        ST_IDLE,   // nothing captured since reset
        ST_MAP,    // stage 1 holds a blanked position
        ST_PIXEL   // stage 1 holds an active pixel
    } tile_stage_e;

endpackage
